// ==== all.f ====
rtl/core_pkg.sv
rtl/register_file.sv
rtl/fetch_stage.sv
rtl/decode_execute_stage.sv
rtl/memory_stage.sv
rtl/core.sv
sim/core_props.sv
sim/core_tb.sv

// ==== Makefile ====
VERILATOR  ?= verilator
FILELIST   ?= all.f
TOP        ?= core_tb
RTL_TOP    ?= core
BUILD_DIR  ?= obj_dir
SIM_FLAGS  ?= --binary --timing --assert
LINT_FLAGS ?= --lint-only -Wall --timing
PASS_MSG   ?= sim passed

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

build:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

sim: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// ==== sim/core_tb.sv ====
`default_nettype none
`timescale 1ns/100ps

module core_tb;

    localparam core_pkg::word_t HALT_ADDR = 32'h0000_0068;
    localparam core_pkg::word_t LOAD_ADDR = 32'h0000_0008;
    localparam int TIMEOUT      = 200;
    localparam int QUIET_CYCLES = 60;
    localparam int NUM_STORES   = 10;

    typedef struct packed {
        core_pkg::word_t addr;
        core_pkg::word_t data;
    } store_t;

    logic            clk            = 1'b0;
    logic            rst_i          = 1'b1;
    logic            instr_rsp_i    = 1'b0;
    core_pkg::word_t instr_data_i   = '0;
    logic            data_mem_rsp_i = 1'b0;
    core_pkg::word_t data_read_i    = '0;
    logic            instr_req_o;
    core_pkg::word_t instr_addr_o;
    logic            data_mem_rd_o;
    logic            data_mem_wr_o;
    core_pkg::word_t data_addr_o;
    core_pkg::word_t data_write_o;
    integer          seed           = 83;
    int              instr_delay;
    int              data_delay;
    core_pkg::word_t imem [64];
    core_pkg::word_t dmem [32];
    store_t          store_table [NUM_STORES];

    core #(
        .BOOT_ADDRESS (32'h0000_0000)
    ) i_dut (
        .clk            (clk),
        .rst_i          (rst_i),
        .instr_req_o    (instr_req_o),
        .instr_addr_o   (instr_addr_o),
        .instr_rsp_i    (instr_rsp_i),
        .instr_data_i   (instr_data_i),
        .data_mem_rd_o  (data_mem_rd_o),
        .data_mem_wr_o  (data_mem_wr_o),
        .data_addr_o    (data_addr_o),
        .data_write_o   (data_write_o),
        .data_mem_rsp_i (data_mem_rsp_i),
        .data_read_i    (data_read_i)
    );

    always #4 clk = ~clk;

    // Both bus slaves, each answering 0 to 3 cycles after the request shows up
    always @(posedge clk) begin
        if (rst_i) begin
            instr_rsp_i    <= 1'b0;
            data_mem_rsp_i <= 1'b0;
            instr_delay    <= 0;
            data_delay     <= 0;
            // Each preloaded word carries its own byte address
            for (int i = 0; i < 32; i++) begin
                dmem[i] <= 32'hD000_0000 + 32'(i * 4);
            end
        end else begin
            instr_rsp_i    <= 1'b0;
            data_mem_rsp_i <= 1'b0;
            if (instr_req_o && !instr_rsp_i) begin
                if (instr_delay == 0) begin
                    instr_rsp_i  <= 1'b1;
                    instr_data_i <= imem[instr_addr_o[7:2]];
                    instr_delay  <= $random(seed) & 3;
                end else begin
                    instr_delay <= instr_delay - 1;
                end
            end
            if ((data_mem_rd_o || data_mem_wr_o) && !data_mem_rsp_i) begin
                if (data_delay == 0) begin
                    data_mem_rsp_i <= 1'b1;
                    data_delay     <= $random(seed) & 3;
                    if (data_mem_rd_o) begin
                        data_read_i <= dmem[data_addr_o[6:2]];
                    end else begin
                        dmem[data_addr_o[6:2]] <= data_write_o;
                    end
                end else begin
                    data_delay <= data_delay - 1;
                end
            end
        end
    end

    task automatic abort_run();
        $display("sim failed");
        $fatal(1, "Stopping at the first error");
    endtask

    task automatic check_word(input string name, input core_pkg::word_t got,
                              input core_pkg::word_t expected);
        if (got !== expected) begin
            $display("FAIL time=%0t %s got=%08h expected=%08h", $time, name, got, expected);
            abort_run();
        end
    endtask

    task automatic wait_store(output core_pkg::word_t addr, output core_pkg::word_t data);
        int   cycles;
        logic seen;
        cycles = 0;
        seen   = 1'b0;
        while (!seen && cycles < TIMEOUT) begin
            @(posedge clk);
            cycles++;
            // The program has a single load
            if (data_mem_rd_o && data_mem_rsp_i) begin
                check_word("data_addr_o", data_addr_o, LOAD_ADDR);
            end
            seen = data_mem_wr_o && data_mem_rsp_i;
        end
        if (!seen) begin
            $display("No data write arrived within %0d cycles", TIMEOUT);
            abort_run();
        end else begin
            addr = data_addr_o;
            data = data_write_o;
        end
    endtask

    task automatic wait_halt();
        int   cycles;
        logic seen;
        cycles = 0;
        seen   = 1'b0;
        while (!seen && cycles < TIMEOUT) begin
            @(posedge clk);
            cycles++;
            seen = instr_req_o && instr_rsp_i && instr_addr_o == HALT_ADDR;
        end
        if (!seen) begin
            $display("The core never fetched the halt loop at %08h", HALT_ADDR);
            abort_run();
        end
    endtask

    // The halt loop spins in place, so no further store may show up
    task automatic watch_quiet();
        int   cycles;
        logic extra;
        cycles = 0;
        extra  = 1'b0;
        while (!extra && cycles < QUIET_CYCLES) begin
            @(posedge clk);
            cycles++;
            extra = data_mem_wr_o && data_mem_rsp_i;
        end
        if (extra) begin
            $display("An extra store to %08h appeared after the last expected one", data_addr_o);
            abort_run();
        end
    endtask

    initial begin
        core_pkg::word_t got_addr;
        core_pkg::word_t got_data;
        for (int i = 0; i < 64; i++) begin
            // Custom-0 opcode, a no-op here
            imem[i] = {i[24:0], 7'b0001011};
        end
        imem[0]  = 32'h05A0_0093;  // addi x1, x0, 0x5a
        imem[1]  = 32'h0330_0113;  // addi x2, x0, 0x33
        imem[2]  = 32'h0020_81B3;  // add  x3, x1, x2
        imem[3]  = 32'h4031_0233;  // sub  x4, x2, x3
        imem[4]  = 32'h0021_F2B3;  // and  x5, x3, x2
        imem[5]  = 32'h0011_E333;  // or   x6, x3, x1
        imem[6]  = 32'h0012_43B3;  // xor  x7, x4, x1
        imem[7]  = 32'h0430_2023;  // sw   x3, 0x40(x0)
        imem[8]  = 32'h0440_2223;  // sw   x4, 0x44(x0)
        imem[9]  = 32'h0450_2423;  // sw   x5, 0x48(x0)
        imem[10] = 32'h0460_2623;  // sw   x6, 0x4c(x0)
        imem[11] = 32'h0470_2823;  // sw   x7, 0x50(x0)
        imem[12] = 32'h1234_5437;  // lui  x8, 0x12345
        imem[13] = 32'h6784_0413;  // addi x8, x8, 0x678
        imem[14] = 32'h0480_2A23;  // sw   x8, 0x54(x0)
        imem[15] = 32'h0080_2483;  // lw   x9, 0x08(x0)
        imem[16] = 32'h0014_8513;  // addi x10, x9, 1
        imem[17] = 32'h04A0_2C23;  // sw   x10, 0x58(x0)
        imem[18] = 32'h0070_8013;  // addi x0, x1, 7
        imem[19] = 32'h0400_2E23;  // sw   x0, 0x5c(x0)
        imem[20] = 32'h0020_8463;  // beq  x1, x2, +8 (not taken)
        imem[21] = 32'h0610_2023;  // sw   x1, 0x60(x0)
        imem[22] = 32'h0052_8663;  // beq  x5, x5, +12 (taken)
        imem[23] = 32'h0620_2223;  // sw   x2, 0x64(x0)
        imem[24] = 32'h0630_2423;  // sw   x3, 0x68(x0)
        imem[25] = 32'h0660_2623;  // sw   x6, 0x6c(x0)
        imem[26] = 32'h0000_0063;  // beq  x0, x0, 0
        // Stores in program order, address then data
        store_table[0] = '{32'h0000_0040, 32'h0000_008D};
        store_table[1] = '{32'h0000_0044, 32'hFFFF_FFA6};
        store_table[2] = '{32'h0000_0048, 32'h0000_0001};
        store_table[3] = '{32'h0000_004C, 32'h0000_00DF};
        store_table[4] = '{32'h0000_0050, 32'hFFFF_FFFC};
        store_table[5] = '{32'h0000_0054, 32'h1234_5678};
        store_table[6] = '{32'h0000_0058, 32'hD000_0009};
        store_table[7] = '{32'h0000_005C, 32'h0000_0000};
        store_table[8] = '{32'h0000_0060, 32'h0000_005A};
        store_table[9] = '{32'h0000_006C, 32'h0000_00DF};
        repeat (3) @(posedge clk);
        rst_i <= 1'b0;
        foreach (store_table[i]) begin
            wait_store(got_addr, got_data);
            check_word("data_addr_o", got_addr, store_table[i].addr);
            check_word("data_write_o", got_data, store_table[i].data);
        end
        wait_halt();
        watch_quiet();
        $display("sim passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim/core_props.sv ====
`default_nettype none
`timescale 1ns/100ps

module core_props (
    input logic            clk,
    input logic            rst_i,
    input logic            instr_req_o,
    input core_pkg::word_t instr_addr_o,
    input logic            instr_rsp_i,
    input logic            data_mem_rd_o,
    input logic            data_mem_wr_o,
    input core_pkg::word_t data_addr_o,
    input core_pkg::word_t data_write_o,
    input logic            data_mem_rsp_i
);

    // Fetch request holds its address until answered
    assert property (@(posedge clk) disable iff (rst_i)
        instr_req_o && !instr_rsp_i |=> instr_req_o && $stable(instr_addr_o))
    else $error("instr_addr_o changed while a fetch was waiting");

    assert property (@(posedge clk) disable iff (rst_i)
        (data_mem_rd_o || data_mem_wr_o) && !data_mem_rsp_i |=>
            $stable({data_mem_rd_o, data_mem_wr_o}) &&
            $stable(data_addr_o) && $stable(data_write_o))
    else $error("data request changed while waiting for its response");

    assert property (@(posedge clk) !(data_mem_rd_o && data_mem_wr_o))
    else $error("data_mem_rd_o and data_mem_wr_o high together");

    // Checked one cycle on, once the reset edge has taken effect
    assert property (@(posedge clk)
        rst_i |=> !instr_req_o && !data_mem_rd_o && !data_mem_wr_o)
    else $error("bus request raised during reset");

endmodule

bind core core_props i_props (.*);

`default_nettype wire

// ==== rtl/core.sv ====
`default_nettype none
`timescale 1ns/100ps

module core #(
    parameter core_pkg::word_t BOOT_ADDRESS = '0
) (
    input  logic            clk,
    input  logic            rst_i,

    // Instruction bus
    output logic            instr_req_o,
    output core_pkg::word_t instr_addr_o,
    input  logic            instr_rsp_i,
    input  core_pkg::word_t instr_data_i,

    // Data bus
    output logic            data_mem_rd_o,
    output logic            data_mem_wr_o,
    output core_pkg::word_t data_addr_o,
    output core_pkg::word_t data_write_o,
    input  logic            data_mem_rsp_i,
    input  core_pkg::word_t data_read_i
);

    core_pkg::fetch_reg_t  fetch_reg;
    core_pkg::exec_reg_t   exec_reg;
    core_pkg::write_back_t write_back;
    core_pkg::reg_addr_t   rs1_addr;
    core_pkg::reg_addr_t   rs2_addr;
    core_pkg::word_t       rs1_data;
    core_pkg::word_t       rs2_data;
    core_pkg::word_t       branch_target;
    logic                  branch_taken;
    logic                  execute_stall;
    logic                  memory_stall;

    fetch_stage #(
        .BOOT_ADDRESS (BOOT_ADDRESS)
    ) i_fetch (
        .clk             (clk),
        .rst_i           (rst_i),
        .branch_taken_i  (branch_taken),
        .branch_target_i (branch_target),
        .execute_stall_i (execute_stall),
        .memory_stall_i  (memory_stall),
        .instr_rsp_i     (instr_rsp_i),
        .instr_data_i    (instr_data_i),
        .fetch_reg_o     (fetch_reg),
        .instr_req_o     (instr_req_o),
        .instr_addr_o    (instr_addr_o)
    );

    decode_execute_stage i_decode_execute (
        .clk             (clk),
        .rst_i           (rst_i),
        .fetch_reg_i     (fetch_reg),
        .rs1_data_i      (rs1_data),
        .rs2_data_i      (rs2_data),
        .write_back_i    (write_back),
        .memory_stall_i  (memory_stall),
        .rs1_addr_o      (rs1_addr),
        .rs2_addr_o      (rs2_addr),
        .exec_reg_o      (exec_reg),
        .branch_taken_o  (branch_taken),
        .branch_target_o (branch_target),
        .execute_stall_o (execute_stall)
    );

    memory_stage i_memory (
        .clk            (clk),
        .rst_i          (rst_i),
        .exec_reg_i     (exec_reg),
        .data_mem_rsp_i (data_mem_rsp_i),
        .data_read_i    (data_read_i),
        .memory_stall_o (memory_stall),
        .write_back_o   (write_back),
        .data_mem_rd_o  (data_mem_rd_o),
        .data_mem_wr_o  (data_mem_wr_o),
        .data_addr_o    (data_addr_o),
        .data_write_o   (data_write_o)
    );

    register_file i_register_file (
        .clk          (clk),
        .write_back_i (write_back),
        .rs1_addr_i   (rs1_addr),
        .rs2_addr_i   (rs2_addr),
        .rs1_data_o   (rs1_data),
        .rs2_data_o   (rs2_data)
    );

endmodule

`default_nettype wire

// ==== rtl/memory_stage.sv ====
`default_nettype none
`timescale 1ns/100ps

module memory_stage (
    input  logic                  clk,
    input  logic                  rst_i,
    input  core_pkg::exec_reg_t   exec_reg_i,
    input  logic                  data_mem_rsp_i,
    input  core_pkg::word_t       data_read_i,
    output logic                  memory_stall_o,
    output core_pkg::write_back_t write_back_o,
    output logic                  data_mem_rd_o,
    output logic                  data_mem_wr_o,
    output core_pkg::word_t       data_addr_o,
    output core_pkg::word_t       data_write_o
);

    typedef enum logic {
        MEM_IDLE,
        MEM_WAIT
    } mem_state_e;

    mem_state_e state_q;
    logic       mem_op;
    logic       done;

    assign mem_op = exec_reg_i.valid && (exec_reg_i.is_load || exec_reg_i.is_store);
    assign done   = (state_q == MEM_WAIT) && data_mem_rsp_i;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state_q <= MEM_IDLE;
        end else begin
            case (state_q)
                MEM_IDLE: begin
                    if (mem_op) begin
                        state_q <= MEM_WAIT;
                    end
                end
                MEM_WAIT: begin
                    if (data_mem_rsp_i) begin
                        state_q <= MEM_IDLE;
                    end
                end
                default: state_q <= MEM_IDLE;
            endcase
        end
    end

    // exec_reg is frozen while waiting, so address and data hold steady
    assign data_mem_rd_o = (state_q == MEM_WAIT) && exec_reg_i.is_load;
    assign data_mem_wr_o = (state_q == MEM_WAIT) && exec_reg_i.is_store;
    assign data_addr_o   = exec_reg_i.result;
    assign data_write_o  = exec_reg_i.store_data;

    assign memory_stall_o = mem_op && !done;

    // ALU results retire at once, loads in their response cycle
    assign write_back_o.en   = exec_reg_i.valid && exec_reg_i.reg_write &&
                               exec_reg_i.rd != '0 && (!exec_reg_i.is_load || done);
    assign write_back_o.addr = exec_reg_i.rd;
    assign write_back_o.data = exec_reg_i.is_load ? data_read_i : exec_reg_i.result;

endmodule

`default_nettype wire

// ==== rtl/decode_execute_stage.sv ====
`default_nettype none
`timescale 1ns/100ps

module decode_execute_stage (
    input  logic                  clk,
    input  logic                  rst_i,
    input  core_pkg::fetch_reg_t  fetch_reg_i,
    input  core_pkg::word_t       rs1_data_i,
    input  core_pkg::word_t       rs2_data_i,
    input  core_pkg::write_back_t write_back_i,
    input  logic                  memory_stall_i,
    output core_pkg::reg_addr_t   rs1_addr_o,
    output core_pkg::reg_addr_t   rs2_addr_o,
    output core_pkg::exec_reg_t   exec_reg_o,
    output logic                  branch_taken_o,
    output core_pkg::word_t       branch_target_o,
    output logic                  execute_stall_o
);

    core_pkg::exec_reg_t exec_reg_q;
    core_pkg::word_t     ir;
    logic [6:0]          opcode;
    logic [2:0]          funct3;
    core_pkg::reg_addr_t rd;
    core_pkg::word_t     imm_i;
    core_pkg::word_t     imm_s;
    core_pkg::word_t     imm_u;
    core_pkg::word_t     imm_b;
    logic                is_r;
    logic                is_imm;
    logic                is_lui;
    logic                is_load;
    logic                is_store;
    logic                is_branch;
    logic                uses_rs1;
    logic                uses_rs2;
    logic                load_use;
    core_pkg::word_t     op_a;
    core_pkg::word_t     op_b;
    core_pkg::word_t     rs2_value;
    core_pkg::word_t     alu_result;
    core_pkg::alu_op_e   alu_op;

    // Newest value first: ALU result in exec_reg, then the write-back port
    function automatic core_pkg::word_t forward(
        input core_pkg::reg_addr_t   addr,
        input core_pkg::word_t       rf_data,
        input core_pkg::exec_reg_t   ex,
        input core_pkg::write_back_t wb
    );
        if (ex.valid && ex.reg_write && !ex.is_load && ex.rd != '0 && ex.rd == addr) begin
            return ex.result;
        end
        if (wb.en && wb.addr == addr) begin
            return wb.data;
        end
        return rf_data;
    endfunction

    assign ir         = fetch_reg_i.ir;
    assign opcode     = ir[6:0];
    assign funct3     = ir[14:12];
    assign rd         = ir[11:7];
    assign rs1_addr_o = ir[19:15];
    assign rs2_addr_o = ir[24:20];

    assign imm_i = {{20{ir[31]}}, ir[31:20]};
    assign imm_s = {{20{ir[31]}}, ir[31:25], ir[11:7]};
    assign imm_u = {ir[31:12], 12'b0};
    assign imm_b = {{19{ir[31]}}, ir[31], ir[7], ir[30:25], ir[11:8], 1'b0};

    // Unknown opcodes match none of these and pass through as no-ops
    assign is_r      = fetch_reg_i.valid && opcode == core_pkg::OP_R;
    assign is_imm    = fetch_reg_i.valid && opcode == core_pkg::OP_IMM;
    assign is_lui    = fetch_reg_i.valid && opcode == core_pkg::OP_LUI;
    assign is_load   = fetch_reg_i.valid && opcode == core_pkg::OP_LOAD;
    assign is_store  = fetch_reg_i.valid && opcode == core_pkg::OP_STORE;
    assign is_branch = fetch_reg_i.valid && opcode == core_pkg::OP_BRANCH;

    assign uses_rs1 = is_r || is_imm || is_load || is_store || is_branch;
    assign uses_rs2 = is_r || is_store || is_branch;

    assign load_use = exec_reg_q.valid && exec_reg_q.is_load && exec_reg_q.rd != '0 &&
                      ((uses_rs1 && rs1_addr_o == exec_reg_q.rd) ||
                       (uses_rs2 && rs2_addr_o == exec_reg_q.rd));
    assign execute_stall_o = load_use;

    assign op_a      = forward(rs1_addr_o, rs1_data_i, exec_reg_q, write_back_i);
    assign rs2_value = forward(rs2_addr_o, rs2_data_i, exec_reg_q, write_back_i);

    always_comb begin
        alu_op = core_pkg::ALU_ADD;
        op_b   = imm_i;
        if (is_r) begin
            op_b = rs2_value;
            case (funct3)
                3'b000: begin
                    if (ir[30]) begin
                        alu_op = core_pkg::ALU_SUB;
                    end
                end
                3'b100: alu_op = core_pkg::ALU_XOR;
                3'b110: alu_op = core_pkg::ALU_OR;
                3'b111: alu_op = core_pkg::ALU_AND;
                default: alu_op = core_pkg::ALU_ADD;
            endcase
        end else if (is_lui) begin
            alu_op = core_pkg::ALU_PASS_B;
            op_b   = imm_u;
        end else if (is_store) begin
            op_b = imm_s;
        end
    end

    always_comb begin
        case (alu_op)
            core_pkg::ALU_ADD: alu_result = op_a + op_b;
            core_pkg::ALU_SUB: alu_result = op_a - op_b;
            core_pkg::ALU_AND: alu_result = op_a & op_b;
            core_pkg::ALU_OR:  alu_result = op_a | op_b;
            core_pkg::ALU_XOR: alu_result = op_a ^ op_b;
            default:           alu_result = op_b;
        endcase
    end

    // BEQ only, and only once it actually leaves decode
    assign branch_taken_o  = is_branch && funct3 == 3'b000 && op_a == rs2_value &&
                             !load_use && !memory_stall_i;
    assign branch_target_o = fetch_reg_i.pc + imm_b;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            exec_reg_q.valid <= 1'b0;
        end else if (!memory_stall_i) begin
            exec_reg_q.valid <= fetch_reg_i.valid && !load_use;
        end
    end

    always_ff @(posedge clk) begin
        if (!memory_stall_i) begin
            exec_reg_q.reg_write  <= is_r || is_imm || is_lui || is_load;
            exec_reg_q.is_load    <= is_load;
            exec_reg_q.is_store   <= is_store;
            exec_reg_q.rd         <= rd;
            exec_reg_q.result     <= alu_result;
            exec_reg_q.store_data <= rs2_value;
        end
    end

    assign exec_reg_o = exec_reg_q;

endmodule

`default_nettype wire

// ==== rtl/fetch_stage.sv ====
`default_nettype none
`timescale 1ns/100ps

module fetch_stage #(
    parameter core_pkg::word_t BOOT_ADDRESS = '0
) (
    input  logic                 clk,
    input  logic                 rst_i,
    input  logic                 branch_taken_i,
    input  core_pkg::word_t      branch_target_i,
    input  logic                 execute_stall_i,
    input  logic                 memory_stall_i,
    input  logic                 instr_rsp_i,
    input  core_pkg::word_t      instr_data_i,
    output core_pkg::fetch_reg_t fetch_reg_o,
    output logic                 instr_req_o,
    output core_pkg::word_t      instr_addr_o
);

    core_pkg::fetch_reg_t fetch_reg_q;
    core_pkg::word_t      pc_q;
    core_pkg::word_t      pc_next;
    core_pkg::word_t      addr_q;
    logic                 req_q;
    logic                 wrong_path_q;
    logic                 stall;
    logic                 accept;
    logic                 issue;

    assign stall = memory_stall_i || execute_stall_i;

    // Response lands in fetch_reg only on the right path and when not held
    assign accept = req_q && instr_rsp_i && !wrong_path_q && !stall && !branch_taken_i;
    assign issue  = (!req_q || instr_rsp_i) && !(stall && fetch_reg_q.valid);

    always_comb begin
        if (branch_taken_i) begin
            pc_next = branch_target_i;
        end else if (accept) begin
            pc_next = pc_q + 32'd4;
        end else begin
            pc_next = pc_q;
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            pc_q              <= BOOT_ADDRESS;
            req_q             <= 1'b0;
            wrong_path_q      <= 1'b0;
            fetch_reg_q.valid <= 1'b0;
        end else begin
            pc_q         <= pc_next;
            req_q        <= issue || (req_q && !instr_rsp_i);
            // Request still in flight for an address left behind by a branch
            wrong_path_q <= (wrong_path_q || branch_taken_i) && req_q && !instr_rsp_i;
            if (accept) begin
                fetch_reg_q.valid <= 1'b1;
            end else if (!stall || branch_taken_i) begin
                fetch_reg_q.valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            addr_q <= pc_next;
        end
        if (accept) begin
            fetch_reg_q.pc <= addr_q;
            fetch_reg_q.ir <= instr_data_i;
        end
    end

    assign fetch_reg_o  = fetch_reg_q;
    assign instr_req_o  = req_q;
    assign instr_addr_o = addr_q;

endmodule

`default_nettype wire

// ==== rtl/register_file.sv ====
`default_nettype none
`timescale 1ns/100ps

module register_file (
    input  logic                  clk,
    input  core_pkg::write_back_t write_back_i,
    input  core_pkg::reg_addr_t   rs1_addr_i,
    input  core_pkg::reg_addr_t   rs2_addr_i,
    output core_pkg::word_t       rs1_data_o,
    output core_pkg::word_t       rs2_data_o
);

    core_pkg::word_t regs [1:31];

    // x0 reads zero, a same-cycle write is passed straight through
    function automatic core_pkg::word_t read_port(
        input core_pkg::reg_addr_t   addr,
        input core_pkg::write_back_t wb,
        input core_pkg::word_t       stored
    );
        if (addr == '0) begin
            return '0;
        end
        if (wb.en && wb.addr == addr) begin
            return wb.data;
        end
        return stored;
    endfunction

    always_ff @(posedge clk) begin
        if (write_back_i.en && write_back_i.addr != '0) begin
            regs[write_back_i.addr] <= write_back_i.data;
        end
    end

    assign rs1_data_o = read_port(rs1_addr_i, write_back_i, regs[rs1_addr_i]);
    assign rs2_data_o = read_port(rs2_addr_i, write_back_i, regs[rs2_addr_i]);

endmodule

`default_nettype wire

// ==== rtl/core_pkg.sv ====
`default_nettype none

package core_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;

    // RV32I major opcodes
    localparam logic [6:0] OP_R      = 7'b0110011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_PASS_B
    } alu_op_e;

    typedef struct packed {
        logic  valid;
        word_t pc;
        word_t ir;
    } fetch_reg_t;

    // Result holds the store address for loads and stores
    typedef struct packed {
        logic      valid;
        logic      reg_write;
        logic      is_load;
        logic      is_store;
        reg_addr_t rd;
        word_t     result;
        word_t     store_data;
    } exec_reg_t;

    typedef struct packed {
        logic      en;
        reg_addr_t addr;
        word_t     data;
    } write_back_t;

endpackage

`default_nettype wire
